// File: build.f
hdl/radio_types_pkg.sv
hdl/fe_regs_pkg.sv
hdl/radio_ifs.sv
hdl/radio_input_stage.sv
hdl/fe_channel.sv
hdl/radio_output_map.sv
hdl/radio_core_top.sv
tests/radio_core_assertions.sv
tests/tb_radio_core.sv

// File: hdl/fe_channel.sv
// one front-end channel: staged/active control, IQ swap and sign correction on rx and tx, LEDs
`timescale 1ns/1ps

module fe_channel import radio_types_pkg::*, fe_regs_pkg::*; #(
   parameter int CHAN_INDEX = 0,
   parameter bit HAS_TX     = 1'b1   // channel drives a DAC
) (
   input  logic    radio_clk,
   input  logic    i_arst_n,
   input  sample_t i_rx,
   input  sample_t i_tx_src,
   input  logic    i_sync_pulse,
   set_bus_if.snk  set_bus,
   fe_out_if.chan  fe_out
);

   fe_ctrl_t    ctrl_staged;
   fe_ctrl_t    ctrl_active;
   logic [31:0] misc_out;
   sample_t     rx_q;
   sample_t     tx_q;
   logic        wr_en;

   // swap first, then negate I, then negate Q
   function automatic sample_t fe_correct(input sample_t s, input fe_ctrl_t c);
      logic [15:0] i_part;
      logic [15:0] q_part;
      i_part = c[CTRL_IQ_SWAP] ? s[15:0] : s[31:16];
      q_part = c[CTRL_IQ_SWAP] ? s[31:16] : s[15:0];
      if (c[CTRL_INV_I])
         i_part = -i_part;
      if (c[CTRL_INV_Q])
         q_part = -q_part;
      return {i_part, q_part};
   endfunction

   assign wr_en = set_bus.stb && (set_bus.chan == chan_sel_t'(CHAN_INDEX));

   //////////////////////////////
   // control registers
   //////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ctrl_staged <= '0;
         ctrl_active <= '0;
         misc_out    <= '0;
      end else begin
         if (wr_en && set_bus.addr == REG_FE_CTRL)
            ctrl_staged <= set_bus.data;
         if (wr_en && set_bus.addr == REG_MISC_OUT)
            misc_out <= set_bus.data;
         if (i_sync_pulse)
            ctrl_active <= ctrl_staged;   // all channels switch on the same pulse
      end
   end

   //////////////////////////////
   // sample paths
   //////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rx_q <= '0;
         tx_q <= '0;
      end else begin
         rx_q <= fe_correct(i_rx, ctrl_active);
         if (HAS_TX && ctrl_active[CTRL_TX_EN])
            tx_q <= fe_correct(i_tx_src, ctrl_active);
         else
            tx_q <= '0;   // DAC idles at zero
      end
   end

   assign fe_out.rx          = rx_q;
   assign fe_out.rx_valid    = ctrl_active[CTRL_RX_EN];
   assign fe_out.tx          = tx_q;
   assign fe_out.misc_out    = misc_out;
   assign fe_out.ctrl_staged = ctrl_staged;
   assign fe_out.ctrl_active = ctrl_active;

   // {RX, TXRX_TX, TXRX_RX}
   assign fe_out.led = {
      ctrl_active[CTRL_RX_EN] &  ctrl_active[CTRL_ANT_RX2],
      ctrl_active[CTRL_TX_EN] &  HAS_TX,
      ctrl_active[CTRL_RX_EN] & ~ctrl_active[CTRL_ANT_RX2]
   };

endmodule

// File: hdl/fe_regs_pkg.sv
// settings-bus and readback address map plus control-word bit positions of a front-end channel

package fe_regs_pkg;

   typedef logic [7:0] fe_addr_t;

   ////////////////////////////////
   // settings write addresses
   ////////////////////////////////
   localparam fe_addr_t REG_FE_CTRL  = 8'h00;  // staged control word
   localparam fe_addr_t REG_MISC_OUT = 8'h01;  // per-channel misc out

   // readback addresses
   localparam fe_addr_t RB_CTRL_STAGED = 8'h00;
   localparam fe_addr_t RB_CTRL_ACTIVE = 8'h01;
   localparam fe_addr_t RB_MISC_IN     = 8'h02;  // misc in of the channel's radio

   ////////////////////////////////
   // control word, low 6 bits used
   ////////////////////////////////
   localparam int CTRL_IQ_SWAP = 0;
   localparam int CTRL_INV_I   = 1;
   localparam int CTRL_INV_Q   = 2;
   localparam int CTRL_RX_EN   = 3;
   localparam int CTRL_TX_EN   = 4;
   localparam int CTRL_ANT_RX2 = 5;  // RX LED instead of TX/RX LED

   typedef logic [31:0] fe_ctrl_t;

endpackage

// File: hdl/radio_core_top.sv
// radio front-end top level: input stage, four correction channels and the pin/readback map
`timescale 1ns/1ps

module radio_core_top import radio_types_pkg::*, fe_regs_pkg::*; (
   input  logic        radio_clk,
   input  logic        i_arst_n,
   // ADC and upstream tx
   input  sample_t     i_rx0,
   input  sample_t     i_rx1,
   input  sample_t     i_tx0_src,
   input  sample_t     i_tx1_src,
   // timing
   input  logic        i_pps,
   input  logic        i_time_sync,
   input  logic [31:0] i_radio0_misc_in,
   input  logic [31:0] i_radio1_misc_in,
   // settings bus
   input  logic        i_set_stb,
   input  chan_sel_t   i_set_chan,
   input  fe_addr_t    i_set_addr,
   input  logic [31:0] i_set_data,
   // readback
   input  chan_sel_t   i_rb_chan,
   input  fe_addr_t    i_rb_addr,
   output logic [31:0] o_rb_data,
   // outputs
   output sample_t     o_rx_data [NUM_CHANS],
   output logic [NUM_CHANS-1:0] o_rx_valid,
   output sample_t     o_tx0,
   output sample_t     o_tx1,
   output led_t        o_radio_led0,
   output led_t        o_radio_led1,
   output logic [31:0] o_radio0_misc_out,
   output logic [31:0] o_radio1_misc_out,
   output logic        o_pps_pulse
);

   sample_t     rx_fan  [NUM_CHANS];
   logic [31:0] misc_in [NUM_RADIOS];
   logic        sync_pulse;

   set_bus_if set_bus ();
   fe_out_if  fe_out [NUM_CHANS] ();

   radio_input_stage u_input (
      .radio_clk   (radio_clk),
      .i_arst_n    (i_arst_n),
      .i_rx0       (i_rx0),
      .i_rx1       (i_rx1),
      .i_pps       (i_pps),
      .i_time_sync (i_time_sync),
      .i_misc_in0  (i_radio0_misc_in),
      .i_misc_in1  (i_radio1_misc_in),
      .i_set_stb   (i_set_stb),
      .i_set_chan  (i_set_chan),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .o_rx_fan    (rx_fan),
      .o_pps_pulse (o_pps_pulse),
      .o_sync_pulse(sync_pulse),
      .o_misc_in   (misc_in),
      .set_bus     (set_bus.src)
   );

   //////////////////////////////
   // channels 0,1 on radio 0 and 2,3 on radio 1
   //////////////////////////////
   for (genvar g = 0; g < NUM_CHANS; g++) begin : g_fe
      fe_channel #(
         .CHAN_INDEX (g),
         .HAS_TX     ((g % CHANS_PER_RADIO) == 0)   // only channel A feeds the DAC
      ) u_chan (
         .radio_clk   (radio_clk),
         .i_arst_n    (i_arst_n),
         .i_rx        (rx_fan[g]),
         .i_tx_src    ((g < CHANS_PER_RADIO) ? i_tx0_src : i_tx1_src),
         .i_sync_pulse(sync_pulse),
         .set_bus     (set_bus.snk),
         .fe_out      (fe_out[g].chan)
      );
   end

   radio_output_map u_map (
      .radio_clk        (radio_clk),
      .i_arst_n         (i_arst_n),
      .i_misc_in        (misc_in),
      .i_rb_chan        (i_rb_chan),
      .i_rb_addr        (i_rb_addr),
      .fe_out           (fe_out),
      .o_rx_data        (o_rx_data),
      .o_rx_valid       (o_rx_valid),
      .o_tx0            (o_tx0),
      .o_tx1            (o_tx1),
      .o_radio_led0     (o_radio_led0),
      .o_radio_led1     (o_radio_led1),
      .o_radio0_misc_out(o_radio0_misc_out),
      .o_radio1_misc_out(o_radio1_misc_out),
      .o_rb_data        (o_rb_data)
   );

endmodule

// File: hdl/radio_ifs.sv
// settings-bus and per-channel output interfaces connecting the input stage, channels and pin map
`timescale 1ns/1ps

// plain strobe bus, no ready, the addressed channel always takes the write
interface set_bus_if import radio_types_pkg::*, fe_regs_pkg::*; ();
   logic      stb;
   chan_sel_t chan;
   fe_addr_t  addr;
   logic [31:0] data;

   modport src (output stb, output chan, output addr, output data);
   modport snk (input stb, input chan, input addr, input data);
endinterface

// everything one channel presents to the output map
interface fe_out_if import radio_types_pkg::*, fe_regs_pkg::*; ();
   sample_t     rx;           // corrected rx sample
   logic        rx_valid;     // active RX_EN
   sample_t     tx;           // corrected tx, zero while TX_EN is off
   led_t        led;
   logic [31:0] misc_out;
   fe_ctrl_t    ctrl_staged;
   fe_ctrl_t    ctrl_active;

   modport chan (
      output rx, output rx_valid, output tx, output led,
      output misc_out, output ctrl_staged, output ctrl_active
   );
   modport map (
      input rx, input rx_valid, input tx, input led,
      input misc_out, input ctrl_staged, input ctrl_active
   );
endinterface

// File: hdl/radio_input_stage.sv
// input stage: syncs PPS and time sync to radio_clk and registers samples, misc in and settings
`timescale 1ns/1ps

module radio_input_stage import radio_types_pkg::*, fe_regs_pkg::*; (
   input  logic        radio_clk,
   input  logic        i_arst_n,
   input  sample_t     i_rx0,
   input  sample_t     i_rx1,
   input  logic        i_pps,
   input  logic        i_time_sync,
   input  logic [31:0] i_misc_in0,
   input  logic [31:0] i_misc_in1,
   input  logic        i_set_stb,
   input  chan_sel_t   i_set_chan,
   input  fe_addr_t    i_set_addr,
   input  logic [31:0] i_set_data,
   output sample_t     o_rx_fan [NUM_CHANS],
   output logic        o_pps_pulse,
   output logic        o_sync_pulse,
   output logic [31:0] o_misc_in [NUM_RADIOS],
   set_bus_if.src      set_bus
);

   logic [2:0] pps_sr;   // two sync flops plus edge history
   logic [2:0] sync_sr;
   sample_t    rx_q [NUM_RADIOS];

   //////////////////////////////
   // PPS and time sync
   //////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pps_sr       <= '0;
         sync_sr      <= '0;
         o_pps_pulse  <= 1'b0;
         o_sync_pulse <= 1'b0;
      end else begin
         pps_sr       <= {pps_sr[1:0], i_pps};
         sync_sr      <= {sync_sr[1:0], i_time_sync};
         o_pps_pulse  <= pps_sr[1] & ~pps_sr[2];   // rising edge, one cycle
         o_sync_pulse <= sync_sr[1] & ~sync_sr[2];
      end
   end

   //////////////////////////////
   // samples, misc in, settings
   //////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rx_q[0]      <= '0;
         rx_q[1]      <= '0;
         o_misc_in[0] <= '0;
         o_misc_in[1] <= '0;
         set_bus.stb  <= 1'b0;
         set_bus.chan <= '0;
         set_bus.addr <= '0;
         set_bus.data <= '0;
      end else begin
         rx_q[0]      <= i_rx0;
         rx_q[1]      <= i_rx1;
         o_misc_in[0] <= i_misc_in0;
         o_misc_in[1] <= i_misc_in1;
         set_bus.stb  <= i_set_stb;
         set_bus.chan <= i_set_chan;
         set_bus.addr <= i_set_addr;
         set_bus.data <= i_set_data;
      end
   end

   // one ADC stream feeds both channels of its radio
   for (genvar c = 0; c < NUM_CHANS; c++) begin : g_fan
      assign o_rx_fan[c] = rx_q[c / CHANS_PER_RADIO];
   end

endmodule

// File: hdl/radio_output_map.sv
// maps the four channels onto DAC, LED and misc pins and answers readback requests
`timescale 1ns/1ps

module radio_output_map import radio_types_pkg::*, fe_regs_pkg::*; (
   input  logic        radio_clk,
   input  logic        i_arst_n,
   input  logic [31:0] i_misc_in [NUM_RADIOS],
   input  chan_sel_t   i_rb_chan,
   input  fe_addr_t    i_rb_addr,
   fe_out_if.map       fe_out [NUM_CHANS],
   output sample_t     o_rx_data [NUM_CHANS],
   output logic [NUM_CHANS-1:0] o_rx_valid,
   output sample_t     o_tx0,
   output sample_t     o_tx1,
   output led_t        o_radio_led0,
   output led_t        o_radio_led1,
   output logic [31:0] o_radio0_misc_out,
   output logic [31:0] o_radio1_misc_out,
   output logic [31:0] o_rb_data
);

   // flat copies so readback can index by channel
   fe_ctrl_t staged [NUM_CHANS];
   fe_ctrl_t active [NUM_CHANS];
   led_t     led    [NUM_CHANS];

   for (genvar c = 0; c < NUM_CHANS; c++) begin : g_chan
      assign o_rx_data[c]  = fe_out[c].rx;
      assign o_rx_valid[c] = fe_out[c].rx_valid;
      assign staged[c]     = fe_out[c].ctrl_staged;
      assign active[c]     = fe_out[c].ctrl_active;
      assign led[c]        = fe_out[c].led;
   end

   // overlay of both channels rather than one LED per channel
   assign o_radio_led0 = led[0] | led[1];
   assign o_radio_led1 = led[2] | led[3];

   //////////////////////////////
   // DAC, misc out, readback
   //////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_tx0             <= '0;
         o_tx1             <= '0;
         o_radio0_misc_out <= '0;
         o_radio1_misc_out <= '0;
         o_rb_data         <= '0;
      end else begin
         o_tx0             <= fe_out[0].tx;        // channel A of radio 0
         o_tx1             <= fe_out[2].tx;        // channel A of radio 1
         o_radio0_misc_out <= fe_out[0].misc_out;
         o_radio1_misc_out <= fe_out[2].misc_out;
         case (i_rb_addr)
            RB_CTRL_STAGED: o_rb_data <= staged[i_rb_chan];
            RB_CTRL_ACTIVE: o_rb_data <= active[i_rb_chan];
            RB_MISC_IN:     o_rb_data <= i_misc_in[i_rb_chan / CHANS_PER_RADIO];
            default:        o_rb_data <= '0;
         endcase
      end
   end

endmodule

// File: hdl/radio_types_pkg.sv
// sample, LED and channel-count types shared by the radio front-end RTL and its testbench

package radio_types_pkg;

   ////////////////////////////////
   // channel counts
   ////////////////////////////////
   localparam int NUM_RADIOS      = 2;
   localparam int CHANS_PER_RADIO = 2;  // both channels of a radio share one ADC
   localparam int NUM_CHANS       = NUM_RADIOS * CHANS_PER_RADIO;

   ////////////////////////////////
   // payload types
   ////////////////////////////////

   // complex sample, I in [31:16], Q in [15:0]
   typedef logic [31:0] sample_t;

   // LED triple {RX, TXRX_TX, TXRX_RX}
   typedef logic [2:0] led_t;

   // front-end channel index
   typedef logic [1:0] chan_sel_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the radio front-end testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_radio_core -o sim_radio_core

status=0
./obj_dir/sim_radio_core > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Some tests failed" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// File: tests/radio_core_assertions.sv
// concurrent checks on DAC idle and PPS pulse width, bound into radio_core_top
`timescale 1ns/1ps

module radio_core_assertions import radio_types_pkg::*, fe_regs_pkg::*; (
   input logic     radio_clk,
   input logic     i_arst_n,
   input fe_ctrl_t i_active0,   // active control of channel 0
   input fe_ctrl_t i_active2,
   input sample_t  i_tx0,
   input sample_t  i_tx1,
   input logic     i_pps_pulse
);

   // DAC pins trail active control by two registers
   a_tx0_idle: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      !$past(i_active0[CTRL_TX_EN], 2) |-> (i_tx0 == '0))
      else $error("o_tx0 nonzero while TX_EN of channel 0 is inactive");

   a_tx1_idle: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      !$past(i_active2[CTRL_TX_EN], 2) |-> (i_tx1 == '0))
      else $error("o_tx1 nonzero while TX_EN of channel 2 is inactive");

   a_pps_single: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      i_pps_pulse |=> !i_pps_pulse)
      else $error("o_pps_pulse high for two cycles");

endmodule

bind radio_core_top radio_core_assertions u_assertions (
   .radio_clk  (radio_clk),
   .i_arst_n   (i_arst_n),
   .i_active0  (fe_out[0].ctrl_active),
   .i_active2  (fe_out[2].ctrl_active),
   .i_tx0      (o_tx0),
   .i_tx1      (o_tx1),
   .i_pps_pulse(o_pps_pulse)
);

// File: tests/tb_radio_core.sv
// directed testbench for radio_core_top run through build.f together with the bound output assertions
`timescale 1ns/1ps

module tb_radio_core import radio_types_pkg::*, fe_regs_pkg::*; ();

   localparam int CLK_PERIOD = 10;
   localparam int RX_BURST   = 10;
   localparam int TX_BURST   = 10;
   // cycle budget per test summed for the watchdog
   localparam int CYC_RESET      = 10;
   localparam int CYC_AFTER_RST  = 10;
   localparam int CYC_ACTIVATION = 30;
   localparam int CYC_RX         = 8 * (4 * 2 + 7 + RX_BURST + 2);
   localparam int CYC_TX         = 4 * 2 + 2 * 7 + TX_BURST + 2 + 4 + 10;
   localparam int CYC_LED        = 40;
   localparam int CYC_PPS        = 12;
   localparam int CYC_MARGIN     = 200;
   localparam int WATCHDOG_NS    = CLK_PERIOD * (CYC_RESET + CYC_AFTER_RST + CYC_ACTIVATION
                                   + CYC_RX + CYC_TX + CYC_LED + CYC_PPS + CYC_MARGIN);

   localparam fe_ctrl_t M_SWAP    = fe_ctrl_t'(1) << CTRL_IQ_SWAP;
   localparam fe_ctrl_t M_INV_Q   = fe_ctrl_t'(1) << CTRL_INV_Q;
   localparam fe_ctrl_t M_RX_EN   = fe_ctrl_t'(1) << CTRL_RX_EN;
   localparam fe_ctrl_t M_TX_EN   = fe_ctrl_t'(1) << CTRL_TX_EN;
   localparam fe_ctrl_t M_ANT_RX2 = fe_ctrl_t'(1) << CTRL_ANT_RX2;

   logic        radio_clk;
   logic        i_arst_n;
   sample_t     i_rx0, i_rx1, i_tx0_src, i_tx1_src;
   logic        i_pps, i_time_sync;
   logic [31:0] i_radio0_misc_in, i_radio1_misc_in;
   logic        i_set_stb;
   chan_sel_t   i_set_chan, i_rb_chan;
   fe_addr_t    i_set_addr, i_rb_addr;
   logic [31:0] i_set_data;
   logic [31:0] o_rb_data;
   sample_t     o_rx_data [NUM_CHANS];
   logic [NUM_CHANS-1:0] o_rx_valid;
   sample_t     o_tx0, o_tx1;
   led_t        o_radio_led0, o_radio_led1;
   logic [31:0] o_radio0_misc_out, o_radio1_misc_out;
   logic        o_pps_pulse;

   logic [31:0] lfsr_state = 32'hfa3dc00f;
   int          test_errors = 0;
   int          total_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   radio_core_top dut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   //////////////////////////////
   // helpers
   //////////////////////////////
   task automatic tick();
      @(posedge radio_clk);
      #1;   // drive phase
   endtask

   // x^32 + x^22 + x^2 + x + 1 stepped once per bit
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < nbits; k++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // expected correction is swap then negate I then negate Q
   function automatic sample_t expect_corrected(input sample_t s, input fe_ctrl_t c);
      logic [15:0] re;
      logic [15:0] im;
      logic [15:0] t;
      re = s[31:16];
      im = s[15:0];
      if (c[CTRL_IQ_SWAP]) begin
         t = re;
         re = im;
         im = t;
      end
      if (c[CTRL_INV_I])
         re = ~re + 16'd1;
      if (c[CTRL_INV_Q])
         im = ~im + 16'd1;
      return {re, im};
   endfunction

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: pass", name);
      end else begin
         $display("%s: FAIL with %0d errors", name, test_errors);
         tests_failed++;
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   // settings write lands in the staged register when this returns
   task automatic write_reg(input chan_sel_t chan, input fe_addr_t addr, input logic [31:0] data);
      i_set_stb  = 1'b1;
      i_set_chan = chan;
      i_set_addr = addr;
      i_set_data = data;
      tick();
      i_set_stb  = 1'b0;
      tick();
   endtask

   task automatic read_reg(input chan_sel_t chan, input fe_addr_t addr, output logic [31:0] data);
      i_rb_chan = chan;
      i_rb_addr = addr;
      tick();
      data = o_rb_data;
   endtask

   task automatic apply_time_sync();
      i_time_sync = 1'b1;
      repeat (4) tick();   // staged is active from here on
      i_time_sync = 1'b0;
      repeat (3) tick();
   endtask

   //////////////////////////////
   // tests
   //////////////////////////////
   task automatic test_after_reset();
      logic [31:0] rb;
      check_equal("o_rx_valid", 32'(o_rx_valid), 32'h0);
      check_equal("o_tx0", o_tx0, 32'h0);
      check_equal("o_tx1", o_tx1, 32'h0);
      check_equal("o_radio_led0", 32'(o_radio_led0), 32'h0);
      check_equal("o_radio_led1", 32'(o_radio_led1), 32'h0);
      for (int c = 0; c < NUM_CHANS; c++) begin
         read_reg(chan_sel_t'(c), RB_CTRL_ACTIVE, rb);
         check_equal($sformatf("o_rb_data active ch%0d", c), rb, 32'h0);
      end
      report_test("after reset");
   endtask

   task automatic test_timed_activation();
      logic [31:0] rb;
      write_reg(2'd1, REG_FE_CTRL, M_RX_EN);
      read_reg(2'd1, RB_CTRL_STAGED, rb);
      check_equal("o_rb_data staged ch1", rb, M_RX_EN);
      read_reg(2'd1, RB_CTRL_ACTIVE, rb);
      check_equal("o_rb_data active ch1", rb, 32'h0);
      i_time_sync = 1'b1;
      repeat (3) tick();
      check_equal("o_rx_valid before sync", 32'(o_rx_valid), 32'h0);
      tick();
      check_equal("o_rx_valid after sync", 32'(o_rx_valid), 32'h2);
      i_time_sync = 1'b0;
      read_reg(2'd1, RB_CTRL_ACTIVE, rb);
      check_equal("o_rb_data active ch1", rb, M_RX_EN);
      repeat (2) tick();
      report_test("timed activation");
   endtask

   task automatic test_rx_correction();
      fe_ctrl_t ctrl [NUM_CHANS];
      sample_t  src  [NUM_RADIOS][RX_BURST];
      sample_t  exp_s;
      for (int k = 0; k < 8; k++) begin
         for (int c = 0; c < NUM_CHANS; c++) begin
            ctrl[c] = fe_ctrl_t'((k + c) % 8) | M_RX_EN;   // every combination on every channel
            write_reg(chan_sel_t'(c), REG_FE_CTRL, ctrl[c]);
         end
         apply_time_sync();
         check_equal("o_rx_valid", 32'(o_rx_valid), 32'hf);
         for (int i = 0; i < RX_BURST + 2; i++) begin
            if (i >= 2) begin
               for (int c = 0; c < NUM_CHANS; c++) begin
                  exp_s = expect_corrected(src[c / CHANS_PER_RADIO][i - 2], ctrl[c]);
                  check_equal($sformatf("o_rx_data[%0d]", c), o_rx_data[c], exp_s);
               end
            end
            if (i < RX_BURST) begin
               src[0][i] = lfsr_take(32);
               src[1][i] = lfsr_take(32);
               i_rx0 = src[0][i];
               i_rx1 = src[1][i];
            end
            tick();
         end
      end
      report_test("rx correction");
   endtask

   task automatic test_tx_path();
      fe_ctrl_t ctrl0;
      fe_ctrl_t ctrl2;
      sample_t  src0 [TX_BURST];
      sample_t  src1 [TX_BURST];
      ctrl0 = M_TX_EN | M_SWAP;
      ctrl2 = M_TX_EN | M_SWAP | M_INV_Q;
      write_reg(2'd0, REG_FE_CTRL, ctrl0);
      write_reg(2'd2, REG_FE_CTRL, ctrl2);
      apply_time_sync();
      for (int i = 0; i < TX_BURST + 2; i++) begin
         if (i >= 2) begin
            check_equal("o_tx0", o_tx0, expect_corrected(src0[i - 2], ctrl0));
            check_equal("o_tx1", o_tx1, expect_corrected(src1[i - 2], ctrl2));
         end
         if (i < TX_BURST) begin
            src0[i] = lfsr_take(32);
            src1[i] = lfsr_take(32);
            i_tx0_src = src0[i];
            i_tx1_src = src1[i];
         end
         tick();
      end
      write_reg(2'd0, REG_FE_CTRL, 32'h0);
      write_reg(2'd2, REG_FE_CTRL, 32'h0);
      apply_time_sync();
      for (int i = 0; i < 4; i++) begin
         i_tx0_src = lfsr_take(32);   // source keeps running while the DAC stays idle
         i_tx1_src = lfsr_take(32);
         tick();
         check_equal("o_tx0", o_tx0, 32'h0);
         check_equal("o_tx1", o_tx1, 32'h0);
      end
      report_test("tx path");
   endtask

   task automatic test_led_and_misc();
      fe_ctrl_t    ctrl [NUM_CHANS];
      logic [31:0] rb;
      ctrl[0] = M_RX_EN | M_ANT_RX2;
      ctrl[1] = M_RX_EN;
      ctrl[2] = M_TX_EN;
      ctrl[3] = M_TX_EN | M_RX_EN;   // channel B has no DAC
      for (int c = 0; c < NUM_CHANS; c++)
         write_reg(chan_sel_t'(c), REG_FE_CTRL, ctrl[c]);
      apply_time_sync();
      // RX from channel 0 and TXRX_RX from channel 1
      check_equal("o_radio_led0", 32'(o_radio_led0), 32'h5);
      // TXRX_TX from channel 2 and TXRX_RX from channel 3
      check_equal("o_radio_led1", 32'(o_radio_led1), 32'h3);
      write_reg(2'd0, REG_MISC_OUT, 32'h0000_a5c3);
      write_reg(2'd2, REG_MISC_OUT, 32'h1234_8001);
      write_reg(2'd1, REG_MISC_OUT, 32'hffff_ffff);   // channel B misc goes nowhere
      tick();
      check_equal("o_radio0_misc_out", o_radio0_misc_out, 32'h0000_a5c3);
      check_equal("o_radio1_misc_out", o_radio1_misc_out, 32'h1234_8001);
      i_radio0_misc_in = lfsr_take(32);
      i_radio1_misc_in = lfsr_take(32);
      tick();
      read_reg(2'd1, RB_MISC_IN, rb);
      check_equal("o_rb_data misc in radio0", rb, i_radio0_misc_in);
      read_reg(2'd3, RB_MISC_IN, rb);
      check_equal("o_rb_data misc in radio1", rb, i_radio1_misc_in);
      report_test("led and misc");
   endtask

   task automatic test_pps();
      int pulses;
      int first_at;
      pulses = 0;
      first_at = -1;
      i_pps = 1'b1;
      for (int n = 1; n <= 8; n++) begin
         tick();
         if (o_pps_pulse) begin
            pulses++;
            if (first_at < 0)
               first_at = n;
         end
      end
      i_pps = 1'b0;
      assert (pulses == 1)
      else begin
         $display("PPS rise gave %0d pulses instead of exactly one", pulses);
         test_errors++;
      end
      assert (first_at == 3)
      else begin
         $display("PPS pulse came %0d cycles after the rise instead of 3", first_at);
         test_errors++;
      end
      report_test("pps");
   endtask

   //////////////////////////////
   // sequence and watchdog
   //////////////////////////////
   initial begin
      i_arst_n = 1'b0;
      {i_rx0, i_rx1, i_tx0_src, i_tx1_src} = '0;
      {i_pps, i_time_sync, i_set_stb} = '0;
      {i_radio0_misc_in, i_radio1_misc_in, i_set_data} = '0;
      {i_set_chan, i_rb_chan, i_set_addr, i_rb_addr} = '0;
      repeat (5) @(posedge radio_clk);
      #1;
      i_arst_n = 1'b1;
      tick();
      test_after_reset();
      test_timed_activation();
      test_rx_correction();
      test_tx_path();
      test_led_and_misc();
      test_pps();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               total_errors);
      if (total_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule
